/* bench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on a falling edge away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* bench/issue_tb.sv */
`timescale 1ns/1ps

`include "core_consts.svh"

module issue_tb;

    localparam int max_cycles = 600;

    logic clk;
    logic rst;
    logic flush;
    logic alu_valid;
    logic ls_valid;
    logic br_valid;
    core_pkg::rs_entry_t alu_entry;
    core_pkg::rs_entry_t ls_entry;
    core_pkg::rs_entry_t br_entry;
    logic [`PHY_W-1:0] rs1_phy_alu;
    logic [`PHY_W-1:0] rs2_phy_alu;
    logic [`PHY_W-1:0] rs1_phy_ls;
    logic [`PHY_W-1:0] rs2_phy_ls;
    logic [`PHY_W-1:0] rs1_phy_br;
    logic [`PHY_W-1:0] rs2_phy_br;
    logic alu_rd_en;
    logic ls_rd_en;
    logic br_rd_en;
    logic [`DATA_W-1:0] rs1_data_alu;
    logic [`DATA_W-1:0] rs2_data_alu;
    logic [`DATA_W-1:0] rs1_data_ls;
    logic [`DATA_W-1:0] rs2_data_ls;
    logic [`DATA_W-1:0] rs1_data_br;
    logic [`DATA_W-1:0] rs2_data_br;
    core_pkg::alu_result_t alu_out;
    core_pkg::ls_result_t ls_out;
    core_pkg::br_result_t br_out;
    logic alu_out_valid;
    logic ls_out_valid;
    logic br_out_valid;

    // register file model and one-deep expected slots
    logic [`DATA_W-1:0] regfile [64];
    core_pkg::alu_result_t exp_alu;
    core_pkg::ls_result_t exp_ls;
    core_pkg::br_result_t exp_br;
    logic exp_alu_v;
    logic exp_ls_v;
    logic exp_br_v;
    int errors;
    int cycles;

    clk_gen #(.period_ns(40), .reset_cycles(10)) u_clk (.clk(clk), .rst(rst));

    issue_stage dut (
        .clk(clk), .rst(rst), .flush(flush),
        .alu_entry(alu_entry), .ls_entry(ls_entry), .br_entry(br_entry),
        .alu_valid(alu_valid), .ls_valid(ls_valid), .br_valid(br_valid),
        .rs1_phy_alu(rs1_phy_alu), .rs2_phy_alu(rs2_phy_alu),
        .rs1_phy_ls(rs1_phy_ls), .rs2_phy_ls(rs2_phy_ls),
        .rs1_phy_br(rs1_phy_br), .rs2_phy_br(rs2_phy_br),
        .alu_rd_en(alu_rd_en), .ls_rd_en(ls_rd_en), .br_rd_en(br_rd_en),
        .rs1_data_alu(rs1_data_alu), .rs2_data_alu(rs2_data_alu),
        .rs1_data_ls(rs1_data_ls), .rs2_data_ls(rs2_data_ls),
        .rs1_data_br(rs1_data_br), .rs2_data_br(rs2_data_br),
        .alu_out(alu_out), .ls_out(ls_out), .br_out(br_out),
        .alu_out_valid(alu_out_valid), .ls_out_valid(ls_out_valid),
        .br_out_valid(br_out_valid)
    );

    assign rs1_data_alu = regfile[rs1_phy_alu];
    assign rs2_data_alu = regfile[rs2_phy_alu];
    assign rs1_data_ls  = regfile[rs1_phy_ls];
    assign rs2_data_ls  = regfile[rs2_phy_ls];
    assign rs1_data_br  = regfile[rs1_phy_br];
    assign rs2_data_br  = regfile[rs2_phy_br];

    function automatic core_pkg::alu_result_t ref_alu(core_pkg::rs_entry_t e,
                                                      logic [31:0] a, logic [31:0] b_reg);
        core_pkg::alu_result_t r;
        logic [31:0] b;
        b = e.use_imm ? e.imm : b_reg;
        r.rob_id = e.rob_id;
        r.rd_phy = e.rd_phy;
        case (e.alu_op)
            core_pkg::alu_add:  r.value = a + b;
            core_pkg::alu_sub:  r.value = a + ~b + 32'd1;
            core_pkg::alu_and:  r.value = a & b;
            core_pkg::alu_or:   r.value = a | b;
            core_pkg::alu_xor:  r.value = a ^ b;
            core_pkg::alu_sll:  r.value = a << b[4:0];
            core_pkg::alu_srl:  r.value = a >> b[4:0];
            core_pkg::alu_sra:  r.value = 32'($signed(a) >>> b[4:0]);
            core_pkg::alu_slt:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::alu_sltu: r.value = (a < b) ? 32'd1 : 32'd0;
            default:            r.value = e.imm;
        endcase
        return r;
    endfunction

    function automatic core_pkg::ls_result_t ref_ls(core_pkg::rs_entry_t e,
                                                    logic [31:0] a, logic [31:0] b);
        core_pkg::ls_result_t r;
        r.rob_id = e.rob_id;
        r.rd_phy = e.rd_phy;
        r.funct3 = e.funct3;
        r.addr = a + e.imm;
        r.mem_read_en = !e.is_store;
        r.wdata_valid = e.is_store;
        r.wdata = e.is_store ? b : 32'd0;
        return r;
    endfunction

    function automatic core_pkg::br_result_t ref_br(core_pkg::rs_entry_t e,
                                                    logic [31:0] a, logic [31:0] b);
        core_pkg::br_result_t r;
        r.rob_id = e.rob_id;
        r.rd_phy = e.rd_phy;
        r.update_pc = e.pc;
        r.link_value = e.pc + 32'd4;
        r.is_jump = (e.br_kind == core_pkg::br_jal) || (e.br_kind == core_pkg::br_jalr);
        r.target = e.pc + e.imm;
        r.taken = 1'b1;
        if (e.br_kind == core_pkg::br_jalr) begin
            r.target = (a + e.imm) & 32'hffff_fffe;
        end else if (e.br_kind == core_pkg::br_cond) begin
            case (e.funct3)
                3'd0:    r.taken = (a == b);
                3'd1:    r.taken = (a != b);
                3'd4:    r.taken = $signed(a) < $signed(b);
                3'd5:    r.taken = !($signed(a) < $signed(b));
                3'd6:    r.taken = a < b;
                default: r.taken = !(a < b);
            endcase
        end
        r.mispredict = (r.taken != e.pred_taken) || (r.taken && r.target != e.pred_target);
        return r;
    endfunction

    function automatic logic [2:0] cond_f3(int k);
        logic [2:0] codes [6];
        codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        return codes[k % 6];
    endfunction

    function automatic core_pkg::rs_entry_t rand_entry();
        core_pkg::rs_entry_t e;
        e.rob_id = `ROB_W'($urandom);
        e.rs1_phy = `PHY_W'($urandom);
        e.rs2_phy = `PHY_W'($urandom);
        e.rd_phy = `PHY_W'($urandom);
        e.alu_op = core_pkg::alu_op_t'($urandom_range(0, 10));
        e.use_imm = 1'($urandom);
        e.funct3 = 3'($urandom);
        e.imm = $urandom;
        e.pc = $urandom;
        e.is_store = 1'($urandom);
        e.br_kind = core_pkg::br_kind_t'($urandom_range(0, 2));
        e.pred_taken = 1'($urandom);
        e.pred_target = $urandom;
        return e;
    endfunction

    // mode 0 right, 1 wrong direction, 2 wrong target
    function automatic core_pkg::rs_entry_t with_pred(core_pkg::rs_entry_t e, int mode);
        core_pkg::br_result_t r;
        r = ref_br(e, regfile[e.rs1_phy], regfile[e.rs2_phy]);
        e.pred_taken = (mode == 1) ? !r.taken : r.taken;
        e.pred_target = (mode == 2) ? (r.target ^ 32'h10) : r.target;
        return e;
    endfunction

    task automatic drive(input core_pkg::rs_entry_t a, input core_pkg::rs_entry_t l,
                         input core_pkg::rs_entry_t b, input logic [2:0] v, input logic fl);
        @(negedge clk);
        alu_entry = a;
        ls_entry = l;
        br_entry = b;
        alu_valid = v[0];
        ls_valid = v[1];
        br_valid = v[2];
        flush = fl;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_alu_v <= 1'b0;
            exp_ls_v <= 1'b0;
            exp_br_v <= 1'b0;
        end else begin
            exp_alu_v <= alu_valid && !flush;
            exp_ls_v <= ls_valid && !flush;
            exp_br_v <= br_valid && !flush;
            exp_alu <= ref_alu(alu_entry, regfile[alu_entry.rs1_phy], regfile[alu_entry.rs2_phy]);
            exp_ls <= ref_ls(ls_entry, regfile[ls_entry.rs1_phy], regfile[ls_entry.rs2_phy]);
            exp_br <= ref_br(br_entry, regfile[br_entry.rs1_phy], regfile[br_entry.rs2_phy]);
        end
    end

    rd_en_check: assert property (@(posedge clk)
        {alu_rd_en, ls_rd_en, br_rd_en} == ({3{!flush}} & {alu_valid, ls_valid, br_valid}))
        else begin
            errors++;
            $display("CHECK FAILED rd_en got %h exp %h",
                     $sampled({alu_rd_en, ls_rd_en, br_rd_en}),
                     $sampled({3{!flush}} & {alu_valid, ls_valid, br_valid}));
        end
    valid_check: assert property (@(posedge clk) disable iff (rst)
        {alu_out_valid, ls_out_valid, br_out_valid} == {exp_alu_v, exp_ls_v, exp_br_v})
        else begin
            errors++;
            $display("CHECK FAILED out_valid got %h exp %h",
                     $sampled({alu_out_valid, ls_out_valid, br_out_valid}),
                     $sampled({exp_alu_v, exp_ls_v, exp_br_v}));
        end
    alu_check: assert property (@(posedge clk) disable iff (rst) exp_alu_v |-> alu_out == exp_alu)
        else begin
            errors++;
            $display("CHECK FAILED alu_out got %h exp %h", $sampled(alu_out), $sampled(exp_alu));
        end
    ls_check: assert property (@(posedge clk) disable iff (rst) exp_ls_v |-> ls_out == exp_ls)
        else begin
            errors++;
            $display("CHECK FAILED ls_out got %h exp %h", $sampled(ls_out), $sampled(exp_ls));
        end
    br_check: assert property (@(posedge clk) disable iff (rst) exp_br_v |-> br_out == exp_br)
        else begin
            errors++;
            $display("CHECK FAILED br_out got %h exp %h", $sampled(br_out), $sampled(exp_br));
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            errors++;
            $display("run stopped after %0d cycles without finishing, errors %0d", cycles, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        core_pkg::rs_entry_t a;
        core_pkg::rs_entry_t l;
        core_pkg::rs_entry_t b;
        errors = 0;
        cycles = 0;
        flush = 1'b0;
        alu_valid = 1'b0;
        ls_valid = 1'b0;
        br_valid = 1'b0;
        alu_entry = '0;
        ls_entry = '0;
        br_entry = '0;
        void'($urandom(32'h406c_202a));
        foreach (regfile[i]) regfile[i] = $urandom;
        @(negedge rst);
        repeat (2) @(negedge clk);
        // every alu_op in both forms, loads and stores, all branch kinds
        for (int i = 0; i < 22; i++) begin
            a = rand_entry();
            a.alu_op = core_pkg::alu_op_t'(i % 11);
            a.use_imm = (i >= 11);
            l = rand_entry();
            l.is_store = i[0];
            b = rand_entry();
            if (i < 16)
                b.br_kind = core_pkg::br_cond;
            else if (i < 19)
                b.br_kind = core_pkg::br_jal;
            else
                b.br_kind = core_pkg::br_jalr;
            b.funct3 = cond_f3(i);
            if (i % 4 < 2)
                b.rs2_phy = b.rs1_phy;
            drive(a, l, b, 3'b111, 1'b0);
            br_entry = with_pred(b, i % 3);
        end
        // issue, then flush over a full cycle, then idle
        drive(rand_entry(), rand_entry(), with_pred(rand_entry(), 0), 3'b111, 1'b0);
        drive(rand_entry(), rand_entry(), with_pred(rand_entry(), 1), 3'b111, 1'b1);
        drive(rand_entry(), rand_entry(), with_pred(rand_entry(), 2), 3'b000, 1'b0);
        for (int i = 0; i < 300; i++) begin
            b = rand_entry();
            b.funct3 = cond_f3($urandom_range(0, 5));
            drive(rand_entry(), rand_entry(), b, 3'($urandom), ($urandom_range(0, 15) == 0));
            br_entry = with_pred(b, $urandom_range(0, 2));
        end
        drive('0, '0, '0, 3'b000, 1'b0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps

`include "core_consts.svh"

module alu_unit (
    input  core_pkg::rs_entry_t   entry,
    input  logic [`DATA_W-1:0]    rs1_data,
    input  logic [`DATA_W-1:0]    rs2_data,
    output core_pkg::alu_result_t result
);

    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [4:0]         shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // immediate forms replace rs2
    assign op_a  = rs1_data;
    assign op_b  = entry.use_imm ? entry.imm : rs2_data;
    assign shamt = op_b[4:0];

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        result.rob_id = entry.rob_id;
        result.rd_phy = entry.rd_phy;
        case (entry.alu_op)
            core_pkg::alu_add:  result.value = op_a + op_b;
            core_pkg::alu_sub:  result.value = op_a - op_b;
            core_pkg::alu_and:  result.value = op_a & op_b;
            core_pkg::alu_or:   result.value = op_a | op_b;
            core_pkg::alu_xor:  result.value = op_a ^ op_b;
            core_pkg::alu_sll:  result.value = op_a << shamt;
            core_pkg::alu_srl:  result.value = op_a >> shamt;
            core_pkg::alu_sra:  result.value = $signed(op_a) >>> shamt;
            core_pkg::alu_slt: begin
                result.value = {{(`DATA_W-1){1'b0}}, lt_signed};
            end
            core_pkg::alu_sltu: begin
                result.value = {{(`DATA_W-1){1'b0}}, lt_unsigned};
            end
            // upper immediate is already shifted by decode
            core_pkg::alu_lui:  result.value = entry.imm;
            default:            result.value = '0;
        endcase
    end

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ps

`include "core_consts.svh"

module branch_unit (
    input  core_pkg::rs_entry_t  entry,
    input  logic [`DATA_W-1:0]   rs1_data,
    input  logic [`DATA_W-1:0]   rs2_data,
    output core_pkg::br_result_t result
);

    logic               cond_taken;
    logic               taken;
    logic [`ADDR_W-1:0] pc_rel;
    logic [`ADDR_W-1:0] reg_rel;
    logic [`ADDR_W-1:0] target;

    // condition from funct3
    always_comb begin
        case (entry.funct3)
            3'b000:  cond_taken = rs1_data == rs2_data;
            3'b001:  cond_taken = rs1_data != rs2_data;
            3'b100:  cond_taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  cond_taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  cond_taken = rs1_data < rs2_data;
            3'b111:  cond_taken = rs1_data >= rs2_data;
            default: cond_taken = 1'b0;
        endcase
    end

    assign pc_rel  = entry.pc + entry.imm;
    assign reg_rel = rs1_data + entry.imm;

    always_comb begin
        case (entry.br_kind)
            core_pkg::br_jal: begin
                taken  = 1'b1;
                target = pc_rel;
            end
            // jalr drops bit 0 of the sum
            core_pkg::br_jalr: begin
                taken  = 1'b1;
                target = {reg_rel[`ADDR_W-1:1], 1'b0};
            end
            default: begin
                taken  = cond_taken;
                target = pc_rel;
            end
        endcase
    end

    always_comb begin
        result.rob_id     = entry.rob_id;
        result.rd_phy     = entry.rd_phy;
        result.taken      = taken;
        result.target     = target;
        result.update_pc  = entry.pc;
        result.link_value = entry.pc + `ADDR_W'd4;
        result.is_jump    = entry.br_kind != core_pkg::br_cond;
        // wrong direction, or right direction with a stale target
        result.mispredict = (taken != entry.pred_taken) ||
                            (taken && (target != entry.pred_target));
    end

endmodule

/* hw/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    // integer alu operations where lui passes the immediate through
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        br_cond,
        br_jal,
        br_jalr
    } br_kind_t;

    // one reservation-station entry as handed to a pipe
    typedef struct packed {
        logic [`ROB_W-1:0]  rob_id;
        logic [`PHY_W-1:0]  rs1_phy;
        logic [`PHY_W-1:0]  rs2_phy;
        logic [`PHY_W-1:0]  rd_phy;
        alu_op_t            alu_op;
        logic               use_imm;
        logic [2:0]         funct3;
        logic [`DATA_W-1:0] imm;
        logic [`ADDR_W-1:0] pc;
        logic               is_store;
        br_kind_t           br_kind;
        logic               pred_taken;
        logic [`ADDR_W-1:0] pred_target;
    } rs_entry_t;

    typedef struct packed {
        logic [`ROB_W-1:0]  rob_id;
        logic [`PHY_W-1:0]  rd_phy;
        logic [`DATA_W-1:0] value;
    } alu_result_t;

    // addr serves as raddr for loads and waddr for stores
    typedef struct packed {
        logic [`ROB_W-1:0]  rob_id;
        logic [`PHY_W-1:0]  rd_phy;
        logic               mem_read_en;
        logic               wdata_valid;
        logic [2:0]         funct3;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } ls_result_t;

    typedef struct packed {
        logic [`ROB_W-1:0]  rob_id;
        logic [`PHY_W-1:0]  rd_phy;
        logic               taken;
        logic               mispredict;
        logic [`ADDR_W-1:0] target;
        logic [`ADDR_W-1:0] update_pc;
        logic [`DATA_W-1:0] link_value;
        logic               is_jump;
    } br_result_t;

endpackage

/* hw/issue_stage.sv */
`timescale 1ns/1ps

`include "core_consts.svh"

module issue_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  core_pkg::rs_entry_t   alu_entry,
    input  core_pkg::rs_entry_t   ls_entry,
    input  core_pkg::rs_entry_t   br_entry,
    input  logic                  alu_valid,
    input  logic                  ls_valid,
    input  logic                  br_valid,
    output logic [`PHY_W-1:0]     rs1_phy_alu,
    output logic [`PHY_W-1:0]     rs2_phy_alu,
    output logic [`PHY_W-1:0]     rs1_phy_ls,
    output logic [`PHY_W-1:0]     rs2_phy_ls,
    output logic [`PHY_W-1:0]     rs1_phy_br,
    output logic [`PHY_W-1:0]     rs2_phy_br,
    output logic                  alu_rd_en,
    output logic                  ls_rd_en,
    output logic                  br_rd_en,
    input  logic [`DATA_W-1:0]    rs1_data_alu,
    input  logic [`DATA_W-1:0]    rs2_data_alu,
    input  logic [`DATA_W-1:0]    rs1_data_ls,
    input  logic [`DATA_W-1:0]    rs2_data_ls,
    input  logic [`DATA_W-1:0]    rs1_data_br,
    input  logic [`DATA_W-1:0]    rs2_data_br,
    output core_pkg::alu_result_t alu_out,
    output core_pkg::ls_result_t  ls_out,
    output core_pkg::br_result_t  br_out,
    output logic                  alu_out_valid,
    output logic                  ls_out_valid,
    output logic                  br_out_valid
);

    logic                  alu_issue;
    logic                  ls_issue;
    logic                  br_issue;
    core_pkg::alu_result_t alu_res;
    core_pkg::ls_result_t  ls_res;
    core_pkg::br_result_t  br_res;

    // flush kills only what is presented this cycle
    assign alu_issue = alu_valid && !flush;
    assign ls_issue  = ls_valid && !flush;
    assign br_issue  = br_valid && !flush;

    assign alu_rd_en = alu_issue;
    assign ls_rd_en  = ls_issue;
    assign br_rd_en  = br_issue;

    // register file read tags straight from the entries
    assign rs1_phy_alu = alu_entry.rs1_phy;
    assign rs2_phy_alu = alu_entry.rs2_phy;
    assign rs1_phy_ls  = ls_entry.rs1_phy;
    assign rs2_phy_ls  = ls_entry.rs2_phy;
    assign rs1_phy_br  = br_entry.rs1_phy;
    assign rs2_phy_br  = br_entry.rs2_phy;

    alu_unit u_alu (
        .entry(alu_entry), .rs1_data(rs1_data_alu), .rs2_data(rs2_data_alu), .result(alu_res)
    );

    ls_unit u_ls (
        .entry(ls_entry), .rs1_data(rs1_data_ls), .rs2_data(rs2_data_ls), .result(ls_res)
    );

    branch_unit u_br (
        .entry(br_entry), .rs1_data(rs1_data_br), .rs2_data(rs2_data_br), .result(br_res)
    );

    // one register stage per pipe
    result_reg #(.payload_t(core_pkg::alu_result_t)) u_alu_reg (
        .clk(clk), .rst(rst), .in_valid(alu_issue), .in_data(alu_res),
        .out_valid(alu_out_valid), .out_data(alu_out)
    );

    result_reg #(.payload_t(core_pkg::ls_result_t)) u_ls_reg (
        .clk(clk), .rst(rst), .in_valid(ls_issue), .in_data(ls_res),
        .out_valid(ls_out_valid), .out_data(ls_out)
    );

    result_reg #(.payload_t(core_pkg::br_result_t)) u_br_reg (
        .clk(clk), .rst(rst), .in_valid(br_issue), .in_data(br_res),
        .out_valid(br_out_valid), .out_data(br_out)
    );

endmodule

/* hw/ls_unit.sv */
`timescale 1ns/1ps

`include "core_consts.svh"

module ls_unit (
    input  core_pkg::rs_entry_t  entry,
    input  logic [`DATA_W-1:0]   rs1_data,
    input  logic [`DATA_W-1:0]   rs2_data,
    output core_pkg::ls_result_t result
);

    logic [`ADDR_W-1:0] eff_addr;

    // base plus offset
    assign eff_addr = rs1_data + entry.imm;

    always_comb begin
        result.rob_id = entry.rob_id;
        result.rd_phy = entry.rd_phy;
        // access size and sign for the memory side to decode
        result.funct3 = entry.funct3;
        result.addr   = eff_addr;

        if (entry.is_store) begin
            result.mem_read_en = 1'b0;
            result.wdata_valid = 1'b1;
            result.wdata       = rs2_data;
        end else begin
            result.mem_read_en = 1'b1;
            result.wdata_valid = 1'b0;
            result.wdata       = '0;
        end
    end

endmodule

/* hw/result_reg.sv */
`timescale 1ns/1ps

// one pipeline stage between execute and writeback, any packed payload
module result_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // loads every cycle, so an idle input gives valid low next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= in_valid;
            out_data  <= in_data;
        end
    end

endmodule

/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// register data width
`define DATA_W 32

// address and pc width
`define ADDR_W 32

// physical register tag
`define PHY_W 6

// rob tag
`define ROB_W 5

`endif

/* project.f */
+incdir+include
hw/core_pkg.sv
hw/result_reg.sv
hw/alu_unit.sv
hw/ls_unit.sv
hw/branch_unit.sv
hw/issue_stage.sv
bench/clk_gen.sv
bench/issue_tb.sv
